//--- include/jtag_dec_defs.svh
`ifndef JTAG_DEC_DEFS_SVH
`define JTAG_DEC_DEFS_SVH

// ====================
// uart data register
`define UART_WORD_W      32
// read data valid flag inside the polled word
`define UART_VALID_BIT   15

// ====================
// stream bytes
`define BYTE_W           8
`define ESC_BYTE         8'hFE
// second byte after the escape prefix
`define ESC_IDLE         8'h00
`define ESC_ACK          8'h01

// command bytes, load is tagged by the two upper bits
`define CMD_LOAD_TAG     2'b10
`define CMD_OFF_H        8'h01
`define CMD_OFF_V        8'h02

// ====================
// image sizes, 16 bytes per frame and up to 64 frames
`define FRAME_SHIFT      4
`define FRAMES_W         7
`define FIFO_DEPTH_LOG2  5
`define OFFSET_CLAMP     8'd128

`endif

//--- design/jtag_dec_pkg.sv
package jtag_dec_pkg;

    // controller states
    typedef enum logic [2:0] {
        idle,
        error,
        wait_ack,
        // image load
        ram_start,
        ram_trigger,
        ram_data,
        // offset update
        off_magnitude,
        off_sign
    } ctrl_state_e;

    // instruction decoded from the byte after an escape
    typedef enum logic [1:0] {
        go_idle,
        ack,
        fault
    } instr_e;

    // command decoded while the controller takes commands
    typedef enum logic [1:0] {
        cmd_load,
        cmd_off_h,
        cmd_off_v,
        cmd_bad
    } cmd_e;

endpackage

//--- design/uart_poll.sv
`include "jtag_dec_defs.svh"

module uart_poll (
    input  logic                    iCLK,
    input  logic                    iRST,
    output logic                    rd_req,
    input  logic [`UART_WORD_W-1:0] rd_data,
    input  logic                    rd_wait,
    output logic [`BYTE_W-1:0]      rx_byte,
    output logic                    byte_valid
);

    // low right after reset, then polling for good
    logic polling;
    // read finished this cycle and the word holds a received byte
    logic got_byte;

    assign rd_req   = polling;
    assign got_byte = polling && !rd_wait && rd_data[`UART_VALID_BIT];

    // ====================
    // control
    always_ff @(posedge iCLK or posedge iRST) begin
        if (iRST) begin
            polling    <= 1'b0;
            byte_valid <= 1'b0;
        end else begin
            polling    <= 1'b1;
            // one cycle pulse per byte
            byte_valid <= got_byte;
        end
    end

    // data is zero latency once wait drops
    always_ff @(posedge iCLK) begin
        rx_byte <= rd_data[`BYTE_W-1:0];
    end

    // no byte can come out before the first read was issued
    a_no_byte_idle: assert property (
        @(posedge iCLK) disable iff (iRST)
        !polling |-> !byte_valid
    );

endmodule

//--- design/stream_parser.sv
`include "jtag_dec_defs.svh"

module stream_parser (
    input  logic                 iCLK,
    input  logic                 iRST,
    input  logic [`BYTE_W-1:0]   rx_byte,
    input  logic                 byte_valid,
    input  logic                 take_cmds,
    output logic                 instr_pending,
    output jtag_dec_pkg::instr_e instr_kind,
    output jtag_dec_pkg::cmd_e   cmd_kind,
    output logic                 data_pending,
    output logic [`BYTE_W-1:0]   data,
    input  logic                 instr_ack,
    input  logic                 data_ack
);

    // last byte was the escape prefix
    logic                 esc_seen;
    logic                 is_esc;
    jtag_dec_pkg::cmd_e   byte_cmd;
    jtag_dec_pkg::instr_e esc_instr;

    assign is_esc = (rx_byte == `ESC_BYTE);

    // ====================
    // byte decode
    always_comb begin
        if (rx_byte[`BYTE_W-1 -: 2] == `CMD_LOAD_TAG) begin
            byte_cmd = jtag_dec_pkg::cmd_load;
        end else if (rx_byte == `CMD_OFF_H) begin
            byte_cmd = jtag_dec_pkg::cmd_off_h;
        end else if (rx_byte == `CMD_OFF_V) begin
            byte_cmd = jtag_dec_pkg::cmd_off_v;
        end else begin
            byte_cmd = jtag_dec_pkg::cmd_bad;
        end
    end

    // only used when the previous byte was FE
    always_comb begin
        case (rx_byte)
            `ESC_IDLE: esc_instr = jtag_dec_pkg::go_idle;
            `ESC_ACK:  esc_instr = jtag_dec_pkg::ack;
            default:   esc_instr = jtag_dec_pkg::fault;
        endcase
    end

    // ====================
    // pending flags
    always_ff @(posedge iCLK or posedge iRST) begin
        if (iRST) begin
            esc_seen      <= 1'b0;
            instr_pending <= 1'b0;
            data_pending  <= 1'b0;
        end else begin
            // flags fall the cycle after their ack
            if (instr_ack) begin
                instr_pending <= 1'b0;
            end
            if (data_ack) begin
                data_pending <= 1'b0;
            end
            // a new byte overrides the ack
            if (byte_valid) begin
                if (esc_seen) begin
                    esc_seen <= 1'b0;
                    // FE FE is plain data FE
                    if (is_esc) begin
                        data_pending <= 1'b1;
                    end else begin
                        instr_pending <= 1'b1;
                    end
                end else if (is_esc) begin
                    esc_seen <= 1'b1;
                end else if (take_cmds) begin
                    instr_pending <= 1'b1;
                    // load carries its frame count as data
                    data_pending  <= (byte_cmd == jtag_dec_pkg::cmd_load);
                end else begin
                    data_pending <= 1'b1;
                end
            end
        end
    end

    // ====================
    // payload
    always_ff @(posedge iCLK) begin
        if (byte_valid) begin
            if (esc_seen && !is_esc) begin
                instr_kind <= esc_instr;
                cmd_kind   <= jtag_dec_pkg::cmd_bad;
            end else if (!esc_seen && !is_esc && take_cmds) begin
                instr_kind <= jtag_dec_pkg::fault;
                cmd_kind   <= byte_cmd;
            end
            // data moves only on a byte that is data or a command
            if (esc_seen == is_esc) begin
                data <= rx_byte;
            end
        end
    end

    // controller acks only what is pending
    a_ack_pending: assert property (
        @(posedge iCLK) disable iff (iRST)
        instr_ack |-> instr_pending
    );

endmodule

//--- design/pixel_fifo.sv
`include "jtag_dec_defs.svh"

module pixel_fifo #(
    parameter int DEPTH_LOG2 = `FIFO_DEPTH_LOG2
) (
    input  logic               iCLK,
    input  logic               iRST,
    input  logic               clear,
    input  logic               wr,
    input  logic [`BYTE_W-1:0] wr_data,
    input  logic               pop,
    output logic [`BYTE_W-1:0] pop_data,
    output logic               empty
);

    localparam int DEPTH = 1 << DEPTH_LOG2;

    logic [`BYTE_W-1:0]  mem [DEPTH];
    logic [DEPTH_LOG2-1:0] wr_ptr;
    logic [DEPTH_LOG2-1:0] rd_ptr;
    // one bit wider so that full is its top bit
    logic [DEPTH_LOG2:0]   count;
    logic                  full;
    logic                  do_wr;
    logic                  do_pop;

    assign full   = count[DEPTH_LOG2];
    assign empty  = (count == '0);
    assign do_wr  = wr && !full;
    assign do_pop = pop && !empty;

    // first-word fall through
    assign pop_data = mem[rd_ptr];

    // ====================
    // pointers and count
    always_ff @(posedge iCLK or posedge iRST) begin
        if (iRST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (clear) begin
            // empty in one cycle, contents left stale
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge iCLK) begin
        if (do_wr && !clear) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // writer and reader sit in different blocks
    a_no_overflow: assert property (
        @(posedge iCLK) disable iff (iRST)
        wr && !clear |-> !full
    );
    a_no_underflow: assert property (
        @(posedge iCLK) disable iff (iRST)
        pop |-> !empty
    );

endmodule

//--- design/cmd_fsm.sv
`include "jtag_dec_defs.svh"

module cmd_fsm (
    input  logic                  iCLK,
    input  logic                  iRST,
    output logic                  take_cmds,
    input  logic                  instr_pending,
    input  jtag_dec_pkg::instr_e  instr_kind,
    input  jtag_dec_pkg::cmd_e    cmd_kind,
    input  logic                  data_pending,
    input  logic [`BYTE_W-1:0]    data,
    output logic                  instr_ack,
    output logic                  data_ack,
    output logic                  fifo_clear,
    output logic                  fifo_wr,
    output logic [`BYTE_W-1:0]    fifo_data,
    output logic [`FRAMES_W-1:0]  num_images,
    output logic                  trigger_write,
    output logic                  error,
    output logic [`BYTE_W-1:0]    h_offset,
    output logic [`BYTE_W-1:0]    v_offset,
    output logic                  h_sign,
    output logic                  v_sign
);

    localparam int CNT_W = `FRAMES_W + `FRAME_SHIFT;

    jtag_dec_pkg::ctrl_state_e state;
    jtag_dec_pkg::ctrl_state_e state_next;
    logic [`FRAMES_W-1:0] frames;
    // data bytes written in the current load
    logic [CNT_W-1:0]     byte_cnt;
    logic [CNT_W-1:0]     total_bytes;
    // axis picked by the last offset command
    logic                 sel_h;
    logic [`BYTE_W-1:0]   h_mag;
    logic [`BYTE_W-1:0]   v_mag;

    // an escape in the middle of a transfer
    function automatic jtag_dec_pkg::ctrl_state_e abort_target(
        input jtag_dec_pkg::instr_e kind
    );
        if (kind == jtag_dec_pkg::go_idle) begin
            return jtag_dec_pkg::idle;
        end
        return jtag_dec_pkg::error;
    endfunction

    assign total_bytes   = {frames, {`FRAME_SHIFT{1'b0}}};
    assign take_cmds     = (state == jtag_dec_pkg::idle) || (state == jtag_dec_pkg::error);
    assign fifo_clear    = (state == jtag_dec_pkg::ram_start);
    assign trigger_write = (state == jtag_dec_pkg::ram_trigger);
    assign error         = (state == jtag_dec_pkg::error);
    assign fifo_data     = data;
    assign num_images    = frames;

    // ====================
    // next state and acks
    always_comb begin
        state_next = state;
        instr_ack  = 1'b0;
        data_ack   = 1'b0;
        fifo_wr    = 1'b0;
        case (state)
            jtag_dec_pkg::idle, jtag_dec_pkg::error: begin
                if (instr_pending) begin
                    instr_ack = 1'b1;
                    if (instr_kind == jtag_dec_pkg::go_idle) begin
                        state_next = jtag_dec_pkg::idle;
                    end else begin
                        case (cmd_kind)
                            jtag_dec_pkg::cmd_load:  state_next = jtag_dec_pkg::ram_start;
                            jtag_dec_pkg::cmd_off_h: state_next = jtag_dec_pkg::off_magnitude;
                            jtag_dec_pkg::cmd_off_v: state_next = jtag_dec_pkg::off_magnitude;
                            default:                 state_next = jtag_dec_pkg::error;
                        endcase
                    end
                end else if (data_pending) begin
                    // stray data is dropped here
                    data_ack = 1'b1;
                end
            end
            jtag_dec_pkg::ram_start: begin
                // frame count came in with the command
                data_ack   = 1'b1;
                state_next = jtag_dec_pkg::ram_trigger;
            end
            jtag_dec_pkg::ram_trigger: begin
                state_next = jtag_dec_pkg::ram_data;
            end
            jtag_dec_pkg::ram_data: begin
                if (instr_pending) begin
                    instr_ack  = 1'b1;
                    state_next = abort_target(instr_kind);
                end else if (data_pending) begin
                    data_ack = 1'b1;
                    fifo_wr  = 1'b1;
                    if (byte_cnt + 1'b1 == total_bytes) begin
                        state_next = jtag_dec_pkg::wait_ack;
                    end
                end
            end
            jtag_dec_pkg::off_magnitude, jtag_dec_pkg::off_sign: begin
                if (instr_pending) begin
                    instr_ack  = 1'b1;
                    state_next = abort_target(instr_kind);
                end else if (data_pending) begin
                    data_ack = 1'b1;
                    if (state == jtag_dec_pkg::off_magnitude) begin
                        state_next = jtag_dec_pkg::off_sign;
                    end else begin
                        state_next = jtag_dec_pkg::wait_ack;
                    end
                end
            end
            jtag_dec_pkg::wait_ack: begin
                // only FE 01 closes a transfer cleanly
                if (instr_pending) begin
                    instr_ack = 1'b1;
                    if (instr_kind == jtag_dec_pkg::ack) begin
                        state_next = jtag_dec_pkg::idle;
                    end else begin
                        state_next = jtag_dec_pkg::error;
                    end
                end else if (data_pending) begin
                    data_ack   = 1'b1;
                    state_next = jtag_dec_pkg::error;
                end
            end
            default: begin
                state_next = jtag_dec_pkg::error;
            end
        endcase
    end

    // ====================
    // registers
    always_ff @(posedge iCLK or posedge iRST) begin
        if (iRST) begin
            state    <= jtag_dec_pkg::idle;
            frames   <= '0;
            byte_cnt <= '0;
            sel_h    <= 1'b0;
            h_mag    <= '0;
            v_mag    <= '0;
            h_sign   <= 1'b0;
            v_sign   <= 1'b0;
        end else begin
            state <= state_next;
            // low six bits plus one, 64 frames fits in seven bits
            if (state == jtag_dec_pkg::ram_start) begin
                frames   <= {1'b0, data[`FRAMES_W-2:0]} + 1'b1;
                byte_cnt <= '0;
            end else if (fifo_wr) begin
                byte_cnt <= byte_cnt + 1'b1;
            end
            if (take_cmds && instr_pending) begin
                sel_h <= (cmd_kind == jtag_dec_pkg::cmd_off_h);
            end
            if (state == jtag_dec_pkg::off_magnitude && data_ack) begin
                if (sel_h) begin
                    h_mag <= data;
                end else begin
                    v_mag <= data;
                end
            end
            // sign is bit 0 of its byte
            if (state == jtag_dec_pkg::off_sign && data_ack) begin
                if (sel_h) begin
                    h_sign <= data[0];
                end else begin
                    v_sign <= data[0];
                end
            end
        end
    end

    // magnitudes of 128 and up show as 128
    assign h_offset = h_mag[`BYTE_W-1] ? `OFFSET_CLAMP : h_mag;
    assign v_offset = v_mag[`BYTE_W-1] ? `OFFSET_CLAMP : v_mag;

    // frame count byte still pending when the load latches it
    a_frame_count_pending: assert property (
        @(posedge iCLK) disable iff (iRST)
        (state == jtag_dec_pkg::ram_start) |-> data_pending
    );

endmodule

//--- design/jtag_uart_decode.sv
`include "jtag_dec_defs.svh"

module jtag_uart_decode (
    input  logic                    iCLK,
    input  logic                    iRST,
    // uart data register
    output logic                    rd_req,
    input  logic [`UART_WORD_W-1:0] rd_data,
    input  logic                    rd_wait,
    // pixel buffer read side
    input  logic                    pop,
    output logic [`BYTE_W-1:0]      pop_data,
    output logic                    empty,
    // decoded results
    output logic [`FRAMES_W-1:0]    num_images,
    output logic                    trigger_write,
    output logic [`BYTE_W-1:0]      h_offset,
    output logic                    h_sign,
    output logic [`BYTE_W-1:0]      v_offset,
    output logic                    v_sign,
    output logic                    error
);

    logic [`BYTE_W-1:0]   rx_byte;
    logic                 byte_valid;
    logic                 take_cmds;
    logic                 instr_pending;
    jtag_dec_pkg::instr_e instr_kind;
    jtag_dec_pkg::cmd_e   cmd_kind;
    logic                 data_pending;
    logic [`BYTE_W-1:0]   data;
    logic                 instr_ack;
    logic                 data_ack;
    logic                 fifo_clear;
    logic                 fifo_wr;
    logic [`BYTE_W-1:0]   fifo_data;

    // ====================
    // byte source
    uart_poll poll0 (
        .iCLK       (iCLK),
        .iRST       (iRST),
        .rd_req     (rd_req),
        .rd_data    (rd_data),
        .rd_wait    (rd_wait),
        .rx_byte    (rx_byte),
        .byte_valid (byte_valid)
    );

    stream_parser parser0 (
        .iCLK          (iCLK),
        .iRST          (iRST),
        .rx_byte       (rx_byte),
        .byte_valid    (byte_valid),
        .take_cmds     (take_cmds),
        .instr_pending (instr_pending),
        .instr_kind    (instr_kind),
        .cmd_kind      (cmd_kind),
        .data_pending  (data_pending),
        .data          (data),
        .instr_ack     (instr_ack),
        .data_ack      (data_ack)
    );

    // ====================
    // controller and image buffer
    cmd_fsm fsm0 (
        .iCLK          (iCLK),
        .iRST          (iRST),
        .take_cmds     (take_cmds),
        .instr_pending (instr_pending),
        .instr_kind    (instr_kind),
        .cmd_kind      (cmd_kind),
        .data_pending  (data_pending),
        .data          (data),
        .instr_ack     (instr_ack),
        .data_ack      (data_ack),
        .fifo_clear    (fifo_clear),
        .fifo_wr       (fifo_wr),
        .fifo_data     (fifo_data),
        .num_images    (num_images),
        .trigger_write (trigger_write),
        .error         (error),
        .h_offset      (h_offset),
        .v_offset      (v_offset),
        .h_sign        (h_sign),
        .v_sign        (v_sign)
    );

    pixel_fifo #(
        .DEPTH_LOG2 (`FIFO_DEPTH_LOG2)
    ) fifo0 (
        .iCLK     (iCLK),
        .iRST     (iRST),
        .clear    (fifo_clear),
        .wr       (fifo_wr),
        .wr_data  (fifo_data),
        .pop      (pop),
        .pop_data (pop_data),
        .empty    (empty)
    );

endmodule

//--- bench/tb_jtag_uart_decode.sv
`include "jtag_dec_defs.svh"

module tb_jtag_uart_decode;

    timeunit 1ns;
    timeprecision 100ps;

    // controller states as the model tracks them
    localparam int ST_IDLE  = 0;
    localparam int ST_ERROR = 1;
    localparam int ST_LOAD  = 2;
    localparam int ST_MAG   = 3;
    localparam int ST_SIGN  = 4;
    localparam int ST_WAIT  = 5;
    // invalid words after every byte, keeps the parser from being overrun
    localparam int GAP_MIN  = 6;

    logic                    iCLK = 1'b0;
    logic                    iRST;
    logic                    rd_req;
    logic [`UART_WORD_W-1:0] rd_data;
    logic                    rd_wait;
    logic                    pop;
    logic [`BYTE_W-1:0]      pop_data;
    logic                    empty;
    logic [`FRAMES_W-1:0]    num_images;
    logic                    trigger_write;
    logic [`BYTE_W-1:0]      h_offset;
    logic                    h_sign;
    logic [`BYTE_W-1:0]      v_offset;
    logic                    v_sign;
    logic                    error;

    // bytes waiting in the uart model
    logic [`BYTE_W-1:0] tx_q[$];
    // every byte sent since reset, input of the reference
    logic [`BYTE_W-1:0] sent[$];
    logic [`BYTE_W-1:0] popped[$];
    logic [`BYTE_W-1:0] exp_buf[$];
    int                 gap = GAP_MIN;
    int                 total_queued = 0;
    int                 cycles = 0;
    int                 errors = 0;
    int                 checks = 0;
    int                 trig_count = 0;
    int                 seed;
    int unsigned        seed_ret;
    logic               wait_now;
    logic [`BYTE_W-1:0] pay;

    // expected results
    int                 exp_frames;
    int                 exp_loads;
    logic               exp_error;
    logic [`BYTE_W-1:0] exp_h_off;
    logic [`BYTE_W-1:0] exp_v_off;
    logic               exp_h_sign;
    logic               exp_v_sign;

    jtag_uart_decode dut0 (
        .iCLK          (iCLK),
        .iRST          (iRST),
        .rd_req        (rd_req),
        .rd_data       (rd_data),
        .rd_wait       (rd_wait),
        .pop           (pop),
        .pop_data      (pop_data),
        .empty         (empty),
        .num_images    (num_images),
        .trigger_write (trigger_write),
        .h_offset      (h_offset),
        .h_sign        (h_sign),
        .v_offset      (v_offset),
        .v_sign        (v_sign),
        .error         (error)
    );

    always #2 iCLK = ~iCLK;

    // ====================
    // uart register model
    always @(posedge iCLK) begin
        #0.5;
        // roughly one wait pulse every four cycles
        wait_now = (($urandom % 4) == 0);
        rd_wait  = wait_now;
        // rd_req is a register, so this word is taken at the next edge
        if (rd_req && !wait_now && tx_q.size() > 0 && gap >= GAP_MIN) begin
            rd_data                  = '0;
            rd_data[`UART_VALID_BIT] = 1'b1;
            rd_data[`BYTE_W-1:0]     = tx_q.pop_front();
            gap                      = 0;
        end else begin
            // junk with the valid bit clear
            rd_data                  = $urandom;
            rd_data[`UART_VALID_BIT] = 1'b0;
            if (gap < 1000) begin
                gap = gap + 1;
            end
        end
    end

    // buffer reader, pops whatever shows up
    always @(posedge iCLK) begin
        #0.5;
        if (!iRST && !empty) begin
            popped.push_back(pop_data);
            pop = 1'b1;
        end else begin
            pop = 1'b0;
        end
    end

    // trigger is one cycle wide, sampled mid cycle
    always @(negedge iCLK) begin
        if (!iRST && trigger_write) begin
            trig_count = trig_count + 1;
        end
    end

    // limit grows with every queued byte
    always @(posedge iCLK) begin
        cycles = cycles + 1;
        if (cycles > 20 * total_queued + 1000) begin
            $display("timeout: byte stream not consumed after %0d cycles", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    // ====================
    // reference model, walks the whole stream from reset
    function automatic void run_reference();
        int                 st;
        int                 cnt;
        int                 total;
        int                 ev;
        logic               esc;
        logic               axis_h;
        logic [`BYTE_W-1:0] b;
        logic [`BYTE_W-1:0] h_mag;
        logic [`BYTE_W-1:0] v_mag;
        st         = ST_IDLE;
        cnt        = 0;
        total      = 0;
        esc        = 1'b0;
        axis_h     = 1'b0;
        h_mag      = '0;
        v_mag      = '0;
        exp_frames = 0;
        exp_loads  = 0;
        exp_h_sign = 1'b0;
        exp_v_sign = 1'b0;
        exp_buf.delete();
        for (int i = 0; i < sent.size(); i++) begin
            b = sent[i];
            // 0 nothing, 1 data, 2 escape instruction, 3 command
            ev = 0;
            if (esc) begin
                esc = 1'b0;
                ev  = (b == `ESC_BYTE) ? 1 : 2;
            end else if (b == `ESC_BYTE) begin
                esc = 1'b1;
            end else if (st == ST_IDLE || st == ST_ERROR) begin
                ev = 3;
            end else begin
                ev = 1;
            end
            if (ev == 3) begin
                if (b[7:6] == 2'b10) begin
                    exp_frames = int'(b[5:0]) + 1;
                    total      = exp_frames << `FRAME_SHIFT;
                    cnt        = 0;
                    exp_loads  = exp_loads + 1;
                    st         = ST_LOAD;
                end else if (b == 8'h01 || b == 8'h02) begin
                    axis_h = (b == 8'h01);
                    st     = ST_MAG;
                end else begin
                    st = ST_ERROR;
                end
            end else if (ev == 2) begin
                // FE 01 only closes a finished transfer, FE 00 aborts elsewhere
                if (st == ST_WAIT) begin
                    st = (b == 8'h01) ? ST_IDLE : ST_ERROR;
                end else begin
                    st = (b == 8'h00) ? ST_IDLE : ST_ERROR;
                end
            end else if (ev == 1) begin
                case (st)
                    ST_LOAD: begin
                        exp_buf.push_back(b);
                        cnt = cnt + 1;
                        if (cnt == total) begin
                            st = ST_WAIT;
                        end
                    end
                    ST_MAG: begin
                        if (axis_h) begin
                            h_mag = b;
                        end else begin
                            v_mag = b;
                        end
                        st = ST_SIGN;
                    end
                    ST_SIGN: begin
                        if (axis_h) begin
                            exp_h_sign = b[0];
                        end else begin
                            exp_v_sign = b[0];
                        end
                        st = ST_WAIT;
                    end
                    ST_WAIT: st = ST_ERROR;
                    // idle and error drop stray data
                    default: ;
                endcase
            end
        end
        exp_error = (st == ST_ERROR);
        exp_h_off = h_mag[7] ? 8'd128 : h_mag;
        exp_v_off = v_mag[7] ? 8'd128 : v_mag;
    endfunction

    task automatic check_val(input string what, input int got, input int exp);
        checks = checks + 1;
        if (got != exp) begin
            errors = errors + 1;
            $display("ERROR at %0.1f ns: %s is %0d, expected %0d", $realtime, what, got, exp);
        end
    endtask

    // ====================
    // stimulus helpers
    task automatic send_byte(input logic [`BYTE_W-1:0] b);
        tx_q.push_back(b);
        sent.push_back(b);
        total_queued = total_queued + 1;
    endtask

    // a data FE needs the escape in front
    task automatic send_data(input logic [`BYTE_W-1:0] b);
        if (b == `ESC_BYTE) begin
            send_byte(`ESC_BYTE);
        end
        send_byte(b);
    endtask

    task automatic send_esc(input logic [`BYTE_W-1:0] code);
        send_byte(`ESC_BYTE);
        send_byte(code);
    endtask

    // the last byte has settled once GAP_MIN idle words followed it
    task automatic drain_stream();
        @(posedge iCLK);
        while (tx_q.size() != 0 || gap < GAP_MIN) begin
            @(posedge iCLK);
        end
        @(negedge iCLK);
    endtask

    task automatic compare_outputs(input string phase);
        int n;
        run_reference();
        // reader keeps polling once out of reset
        check_val({phase, ": rd_req"}, rd_req, 1);
        check_val({phase, ": num_images"}, num_images, exp_frames);
        check_val({phase, ": trigger pulses"}, trig_count, exp_loads);
        check_val({phase, ": error"}, error, exp_error);
        check_val({phase, ": h_offset"}, h_offset, exp_h_off);
        check_val({phase, ": h_sign"}, h_sign, exp_h_sign);
        check_val({phase, ": v_offset"}, v_offset, exp_v_off);
        check_val({phase, ": v_sign"}, v_sign, exp_v_sign);
        check_val({phase, ": bytes read from buffer"}, popped.size(), exp_buf.size());
        check_val({phase, ": buffer empty"}, empty, 1);
        n = (popped.size() < exp_buf.size()) ? popped.size() : exp_buf.size();
        for (int i = 0; i < n; i++) begin
            check_val($sformatf("%s: buffer byte %0d", phase, i), popped[i], exp_buf[i]);
        end
    endtask

    // ====================
    // test sequence
    initial begin
        iRST    = 1'b1;
        rd_data = '0;
        rd_wait = 1'b0;
        pop     = 1'b0;
        seed     = 32'h452eab3a;
        seed_ret = $urandom(seed);
        repeat (4) @(posedge iCLK);
        #0.5;
        iRST = 1'b0;

        // two frames with a few escaped FE bytes
        send_byte(8'h81);
        for (int i = 0; i < 32; i++) begin
            pay = $urandom;
            if (i == 3 || i == 4 || i == 19 || i == 31) begin
                pay = `ESC_BYTE;
            end
            send_data(pay);
        end
        send_esc(`ESC_ACK);
        drain_stream();
        compare_outputs("load");

        // h 5 negative, then v 200 which shows as 128
        send_byte(8'h01);
        send_data(8'd5);
        send_data(8'h01);
        send_esc(`ESC_ACK);
        send_byte(8'h02);
        send_data(8'd200);
        send_data(8'h00);
        send_esc(`ESC_ACK);
        drain_stream();
        compare_outputs("offsets");

        // unknown command, then recovery through an offset update
        send_byte(8'h33);
        drain_stream();
        compare_outputs("bad command");
        send_byte(8'h01);
        send_data(8'd10);
        send_data(8'h00);
        send_esc(`ESC_ACK);
        drain_stream();
        compare_outputs("recover");

        // one frame cut short by FE 00
        send_byte(8'h80);
        for (int i = 0; i < 5; i++) begin
            send_data(8'h40 + i);
        end
        send_esc(`ESC_IDLE);
        drain_stream();
        compare_outputs("abort");

        // data where FE 01 belongs
        send_byte(8'h02);
        send_data(8'd7);
        send_data(8'h01);
        send_data(8'h55);
        drain_stream();
        compare_outputs("data instead of ack");
        // wrong escape code where FE 01 belongs
        send_esc(`ESC_IDLE);
        send_byte(8'h01);
        send_data(8'd3);
        send_data(8'h01);
        send_esc(8'h05);
        drain_stream();
        compare_outputs("bad escape");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+include
design/jtag_dec_pkg.sv
design/uart_poll.sv
design/stream_parser.sv
design/pixel_fifo.sv
design/cmd_fsm.sv
design/jtag_uart_decode.sv
bench/tb_jtag_uart_decode.sv
